// File: build.f
source/board_pkg.sv
source/reset_heartbeat.sv
source/gpio_port.sv
source/uart_tx.sv
source/soc_regs.sv
source/board_top.sv
test/board_top_checker.sv
test/tb_board_top.sv

// File: source/board_pkg.sv
// board package
// register map, bus widths and status word layout shared by the board RTL

package board_pkg;

  // host register port
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;

  // register map
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL     = 4'h0;
  localparam logic [REG_ADDR_W-1:0] ADDR_GPIO_OUT = 4'h1;
  localparam logic [REG_ADDR_W-1:0] ADDR_GPIO_IN  = 4'h2;
  localparam logic [REG_ADDR_W-1:0] ADDR_UART_TX  = 4'h3;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS   = 4'h4;
  localparam logic [REG_ADDR_W-1:0] ADDR_EXIT     = 4'h5;

  // status word bit positions
  localparam int STAT_BOOT_SEL   = 0;
  localparam int STAT_EXEC_FLASH = 1;
  localparam int STAT_UART_BUSY  = 2;
  localparam int STAT_UART_OVF   = 3;

  // uart character width, 8N1 framing
  localparam int UART_DATA_W = 8;

  // flops in every synchronizer chain, reset release included
  localparam int SYNC_STAGES = 2;

endpackage

// File: source/board_top.sv
// board top
// reset and heartbeat glue, register block, gpio pads and uart tx on pins

module board_top
  import board_pkg::*;
#(
  parameter int HEARTBEAT_BITS = 27,
  parameter int GPIO_WIDTH     = 8,
  parameter int UART_DIV       = 868
) (
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  logic                  reg_we_i,
  input  logic                  reg_re_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [REG_DATA_W-1:0] reg_wdata_i,
  output logic [REG_DATA_W-1:0] reg_rdata_o,
  output logic                  reg_rvalid_o,
  input  logic                  boot_select_i,
  input  logic                  execute_from_flash_i,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  uart_tx_o,
  output logic                  exit_value_o,
  output logic                  exit_valid_o,
  output logic                  rst_led_o,
  output logic                  clk_led_o,
  output logic                  clk_out_o
);

  logic                   sys_rst_n;
  logic [GPIO_WIDTH-1:0]  gpio_oe;
  logic [GPIO_WIDTH-1:0]  gpio_out;
  logic [GPIO_WIDTH-1:0]  gpio_in_sync;
  logic                   uart_busy;
  logic                   tx_start;
  logic [UART_DATA_W-1:0] tx_byte;

  // board clock goes out unchanged for scope probing
  assign clk_out_o = clk_gen;

  reset_heartbeat #(
    .HEARTBEAT_BITS(HEARTBEAT_BITS)
  ) reset_heartbeat_i (
    .clk_gen    (clk_gen),
    .rst_n      (rst_n),
    .sys_rst_n_o(sys_rst_n),
    .rst_led_o  (rst_led_o),
    .clk_led_o  (clk_led_o)
  );

  soc_regs #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) soc_regs_i (
    .clk_gen             (clk_gen),
    .rst_n               (sys_rst_n),
    .reg_we_i            (reg_we_i),
    .reg_re_i            (reg_re_i),
    .reg_addr_i          (reg_addr_i),
    .reg_wdata_i         (reg_wdata_i),
    .reg_rdata_o         (reg_rdata_o),
    .reg_rvalid_o        (reg_rvalid_o),
    .boot_select_i       (boot_select_i),
    .execute_from_flash_i(execute_from_flash_i),
    .gpio_in_i           (gpio_in_sync),
    .uart_busy_i         (uart_busy),
    .gpio_oe_o           (gpio_oe),
    .gpio_out_o          (gpio_out),
    .tx_start_o          (tx_start),
    .tx_byte_o           (tx_byte),
    .exit_valid_o        (exit_valid_o),
    .exit_value_o        (exit_value_o)
  );

  gpio_port #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio_port_i (
    .clk_gen  (clk_gen),
    .rst_n    (sys_rst_n),
    .oe_i     (gpio_oe),
    .out_i    (gpio_out),
    .pins_i   (gpio_i),
    .gpio_o   (gpio_o),
    .gpio_oe_o(gpio_oe_o),
    .in_sync_o(gpio_in_sync)
  );

  uart_tx #(
    .UART_DIV(UART_DIV)
  ) uart_tx_i (
    .clk_gen(clk_gen),
    .rst_n  (sys_rst_n),
    .start_i(tx_start),
    .byte_i (tx_byte),
    .tx_o   (uart_tx_o),
    .busy_o (uart_busy)
  );

endmodule

// File: source/gpio_port.sv
// gpio pad stage
// registers output value and enable toward the pads and
// synchronizes the input pins

module gpio_port
  import board_pkg::*;
#(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  logic [GPIO_WIDTH-1:0] oe_i,
  input  logic [GPIO_WIDTH-1:0] out_i,
  input  logic [GPIO_WIDTH-1:0] pins_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic [GPIO_WIDTH-1:0] in_sync_o
);

  logic [GPIO_WIDTH-1:0]                  gpio_q;
  logic [GPIO_WIDTH-1:0]                  oe_q;
  logic [SYNC_STAGES-1:0][GPIO_WIDTH-1:0] in_sync_q;

  // pad-side output flops
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      gpio_q <= '0;
      oe_q   <= '0;
    end else begin
      gpio_q <= out_i;
      oe_q   <= oe_i;
    end
  end

  // pins are asynchronous to clk_gen
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      in_sync_q <= '0;
    end else begin
      in_sync_q <= {in_sync_q[SYNC_STAGES-2:0], pins_i};
    end
  end

  assign gpio_o    = gpio_q;
  assign gpio_oe_o = oe_q;
  assign in_sync_o = in_sync_q[SYNC_STAGES-1];

endmodule

// File: source/reset_heartbeat.sv
// reset and heartbeat glue
// async-assert / sync-release reset plus a free-running LED blink counter

module reset_heartbeat
  import board_pkg::*;
#(
  parameter int HEARTBEAT_BITS = 27
) (
  input  logic clk_gen,
  input  logic rst_n,
  output logic sys_rst_n_o,
  output logic rst_led_o,
  output logic clk_led_o
);

  logic [SYNC_STAGES-1:0]    rst_sync_q;
  logic [HEARTBEAT_BITS-1:0] beat_cnt_q;

  // ones shift in after rst_n rises
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign sys_rst_n_o = rst_sync_q[SYNC_STAGES-1];

  always_ff @(posedge clk_gen or negedge sys_rst_n_o) begin
    if (!sys_rst_n_o) begin
      beat_cnt_q <= '0;
    end else begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // led lights once the system is out of reset
  assign rst_led_o = sys_rst_n_o;
  assign clk_led_o = beat_cnt_q[HEARTBEAT_BITS-1];

endmodule

// File: source/soc_regs.sv
// board register block
// decodes the host register port, holds gpio, exit and status state
// and launches uart bytes

module soc_regs
  import board_pkg::*;
#(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  logic                   reg_we_i,
  input  logic                   reg_re_i,
  input  logic [REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [REG_DATA_W-1:0]  reg_wdata_i,
  output logic [REG_DATA_W-1:0]  reg_rdata_o,
  output logic                   reg_rvalid_o,
  input  logic                   boot_select_i,
  input  logic                   execute_from_flash_i,
  input  logic [GPIO_WIDTH-1:0]  gpio_in_i,
  input  logic                   uart_busy_i,
  output logic [GPIO_WIDTH-1:0]  gpio_oe_o,
  output logic [GPIO_WIDTH-1:0]  gpio_out_o,
  output logic                   tx_start_o,
  output logic [UART_DATA_W-1:0] tx_byte_o,
  output logic                   exit_valid_o,
  output logic                   exit_value_o
);

  logic [GPIO_WIDTH-1:0]        ctrl_q;
  logic [GPIO_WIDTH-1:0]        gpio_out_q;
  logic [REG_DATA_W-1:0]        exit_code_q;
  logic                         exit_valid_q;
  logic                         ovf_q;
  logic [SYNC_STAGES-1:0][1:0]  boot_sync_q;
  logic [1:0]                   boot_pins;
  logic                         uart_wr;
  logic                         status_rd;
  logic [REG_DATA_W-1:0]        status_word;
  logic [REG_DATA_W-1:0]        rdata_d;
  logic [REG_DATA_W-1:0]        rdata_q;
  logic                         rvalid_q;

  assign uart_wr   = reg_we_i && (reg_addr_i == ADDR_UART_TX);
  assign status_rd = reg_re_i && (reg_addr_i == ADDR_STATUS);

  // byte goes straight to the transmitter when it is idle
  assign tx_start_o = uart_wr && !uart_busy_i;
  assign tx_byte_o  = reg_wdata_i[UART_DATA_W-1:0];

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q       <= '0;
      gpio_out_q   <= '0;
      exit_code_q  <= '0;
      exit_valid_q <= 1'b0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        ADDR_CTRL:     ctrl_q <= reg_wdata_i[GPIO_WIDTH-1:0];
        ADDR_GPIO_OUT: gpio_out_q <= reg_wdata_i[GPIO_WIDTH-1:0];
        ADDR_EXIT: begin
          exit_code_q  <= reg_wdata_i;
          exit_valid_q <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // sticky until status is read
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      ovf_q <= 1'b0;
    end else if (uart_wr && uart_busy_i) begin
      ovf_q <= 1'b1;
    end else if (status_rd) begin
      ovf_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      boot_sync_q <= '0;
    end else begin
      boot_sync_q <= {boot_sync_q[SYNC_STAGES-2:0], {execute_from_flash_i, boot_select_i}};
    end
  end

  assign boot_pins = boot_sync_q[SYNC_STAGES-1];

  always_comb begin
    status_word                  = '0;
    status_word[STAT_BOOT_SEL]   = boot_pins[0];
    status_word[STAT_EXEC_FLASH] = boot_pins[1];
    status_word[STAT_UART_BUSY]  = uart_busy_i;
    status_word[STAT_UART_OVF]   = ovf_q;
  end

  // uart tx and unmapped addresses read as zero
  always_comb begin
    case (reg_addr_i)
      ADDR_CTRL:     rdata_d = REG_DATA_W'(ctrl_q);
      ADDR_GPIO_OUT: rdata_d = REG_DATA_W'(gpio_out_q);
      ADDR_GPIO_IN:  rdata_d = REG_DATA_W'(gpio_in_i);
      ADDR_STATUS:   rdata_d = status_word;
      ADDR_EXIT:     rdata_d = exit_code_q;
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_gen) begin
    if (reg_re_i) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_re_i;
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;
  assign gpio_oe_o    = ctrl_q;
  assign gpio_out_o   = gpio_out_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_code_q[0];

endmodule

// File: source/uart_tx.sv
// uart transmitter
// 8N1 frames, one bit every UART_DIV clocks, line idles high

module uart_tx
  import board_pkg::*;
#(
  parameter int UART_DIV = 868
) (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  logic                   start_i,
  input  logic [UART_DATA_W-1:0] byte_i,
  output logic                   tx_o,
  output logic                   busy_o
);

  // start + data + stop
  localparam int FRAME_BITS = UART_DATA_W + 2;
  localparam int DIV_W      = (UART_DIV > 1) ? $clog2(UART_DIV) : 1;
  localparam int BIT_W      = $clog2(FRAME_BITS);

  logic [FRAME_BITS-1:0] shift_q;
  logic [DIV_W-1:0]      div_cnt_q;
  logic [BIT_W-1:0]      bit_cnt_q;
  logic                  busy_q;
  logic                  bit_end;

  assign bit_end = (div_cnt_q == DIV_W'(UART_DIV - 1));

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      shift_q   <= '1;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (!busy_q) begin
      if (start_i) begin
        shift_q   <= {1'b1, byte_i, 1'b0};
        div_cnt_q <= '0;
        bit_cnt_q <= '0;
        busy_q    <= 1'b1;
      end
    end else if (bit_end) begin
      div_cnt_q <= '0;
      // ones fill in behind the stop bit
      shift_q   <= {1'b1, shift_q[FRAME_BITS-1:1]};
      if (bit_cnt_q == BIT_W'(FRAME_BITS - 1)) begin
        busy_q <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  assign tx_o   = shift_q[0];
  assign busy_o = busy_q;

endmodule

// File: test/board_patterns.hex
// columns: opcode_address_data_expected (op 0 write, 1 read, 2 pins, 3 uart, 4 wait)
// reads of GPIO_IN expect the driven pins, the expected column is unused there
0_0_000000a5_000000a5
0_1_0000003c_0000003c
1_0_00000000_000000a5
1_1_00000000_0000003c
1_7_00000000_00000000
1_3_00000000_00000000
2_0_00000001_00000000
1_2_00000000_00000000
1_4_00000000_00000001
2_0_00000002_00000000
1_2_00000000_00000000
1_4_00000000_00000002
3_0_00000055_00000006
1_4_00000000_00000002
3_0_0001c3a6_0000000e
1_4_00000000_00000002
4_0_00000003_00000000
0_5_00000007_00000003
1_5_00000000_00000007
0_5_12345678_00000002
1_5_00000000_12345678
1_f_00000000_00000000

// File: test/board_top_checker.sv
// board top checker
// bound assertions on read valid timing, uart idle level and sticky exit flag

module board_top_checker (
  input logic clk_gen,
  input logic sys_rst_n_i,
  input logic reg_re_i,
  input logic reg_rvalid_i,
  input logic uart_busy_i,
  input logic uart_tx_i,
  input logic exit_valid_i
);

  int assert_errors = 0;

  // valid is the strobe delayed by one cycle
  assert property (@(posedge clk_gen) disable iff (!sys_rst_n_i) reg_re_i |=> reg_rvalid_i)
    else begin $error("read valid missing after read strobe"); assert_errors++; end
  assert property (@(posedge clk_gen) disable iff (!sys_rst_n_i) !reg_re_i |=> !reg_rvalid_i)
    else begin $error("read valid without read strobe"); assert_errors++; end

  assert property (@(posedge clk_gen) disable iff (!sys_rst_n_i) !uart_busy_i |-> uart_tx_i)
    else begin $error("uart line low while transmitter idle"); assert_errors++; end

  assert property (@(posedge clk_gen) disable iff (!sys_rst_n_i) exit_valid_i |=> exit_valid_i)
    else begin $error("exit valid fell outside reset"); assert_errors++; end

endmodule

bind board_top board_top_checker board_top_checker_i (
  .clk_gen     (clk_gen),
  .sys_rst_n_i (sys_rst_n),
  .reg_re_i    (reg_re_i),
  .reg_rvalid_i(reg_rvalid_o),
  .uart_busy_i (uart_busy),
  .uart_tx_i   (uart_tx_o),
  .exit_valid_i(exit_valid_o)
);

// File: test/tb_board_top.sv
// board top testbench
// replays register patterns from a hex file, checks pins, uart frames and read data

module tb_board_top
  import board_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int HEARTBEAT_BITS = 4;
  localparam int GPIO_WIDTH = 8;
  localparam int UART_DIV = 4;
  localparam int MAX_PAT = 64;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic clk_gen = 1'b0;
  logic rst_n, reg_we, reg_re, reg_rvalid, boot_select, execute_from_flash;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata, reg_rdata;
  logic [GPIO_WIDTH-1:0] gpio_in, gpio_out, gpio_oe, pins_q;
  logic uart_tx, exit_value, exit_valid, rst_led, clk_led, clk_out;
  logic [71:0] pat_mem [MAX_PAT];
  logic [31:0] lfsr_q;
  logic loaded = 1'b0;
  int n_pat, errors, checks;

  always #(CLK_PERIOD / 2) clk_gen = ~clk_gen;

  board_top #(
    .HEARTBEAT_BITS(HEARTBEAT_BITS),
    .GPIO_WIDTH    (GPIO_WIDTH),
    .UART_DIV      (UART_DIV)
  ) board_top_i (
    .clk_gen(clk_gen), .rst_n(rst_n), .reg_we_i(reg_we), .reg_re_i(reg_re),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .reg_rvalid_o(reg_rvalid), .boot_select_i(boot_select),
    .execute_from_flash_i(execute_from_flash), .gpio_i(gpio_in), .gpio_o(gpio_out),
    .gpio_oe_o(gpio_oe), .uart_tx_o(uart_tx), .exit_value_o(exit_value),
    .exit_valid_o(exit_valid), .rst_led_o(rst_led), .clk_led_o(clk_led), .clk_out_o(clk_out)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk_gen);
    #1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk_gen);
    #1;
    reg_we = 1'b0;
  endtask

  // data captured on the strobe edge, valid for the one cycle after it
  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk_gen);
    #1;
    reg_re   = 1'b1;
    reg_addr = addr;
    @(posedge clk_gen);
    #1;
    reg_re = 1'b0;
    compare_value("reg_rvalid_o", reg_rvalid, 1);
    data = reg_rdata;
    @(posedge clk_gen);
    #1;
    compare_value("reg_rvalid_o", reg_rvalid, 0);
  endtask

  task automatic drive_pins(input logic [1:0] boot);
    @(posedge clk_gen);
    #1;
    for (int b = 0; b < GPIO_WIDTH; b++) begin
      pins_q[b] = lfsr_q[0];
      lfsr_q    = lfsr_next(lfsr_q);
    end
    gpio_in            = pins_q;
    boot_select        = boot[0];
    execute_from_flash = boot[1];
    // let both synchronizer stages settle
    repeat (2) @(posedge clk_gen);
    #1;
  endtask

  // data[16] adds a second byte written while the frame is on the line
  task automatic send_uart(input logic [31:0] data, input logic [31:0] status_exp);
    logic [9:0]  frame;
    logic [31:0] status;
    int          polls;
    frame = {1'b1, data[7:0], 1'b0};
    fork
      begin
        reg_write(ADDR_UART_TX, data[7:0]);
        if (data[16]) begin
          reg_write(ADDR_UART_TX, data[15:8]);
        end
        reg_read(ADDR_STATUS, status);
        compare_value("reg_rdata_o status during frame", status, status_exp);
      end
      begin
        polls = 0;
        do begin
          @(posedge clk_gen);
          #1;
          polls++;
        end while (uart_tx === 1'b1 && polls < 8);
        if (uart_tx !== 1'b0) begin
          $display("no start bit seen on uart_tx_o after the byte was written");
          errors++;
        end else begin
          repeat (UART_DIV / 2) @(posedge clk_gen);
          for (int b = 0; b < 10; b++) begin
            #1;
            compare_value("uart_tx_o", uart_tx, frame[b]);
            repeat (UART_DIV) @(posedge clk_gen);
          end
        end
      end
    join
  endtask

  task automatic check_reset_and_heartbeat();
    logic prev;
    int   cnt;
    int   toggles;
    repeat (5) @(posedge clk_gen);
    #1;
    compare_value("rst_led_o", rst_led, 0);
    rst_n = 1'b1;
    repeat (2) @(posedge clk_gen);
    #1;
    compare_value("rst_led_o", rst_led, 1);
    compare_value("uart_tx_o", uart_tx, 1);
    compare_value("exit_valid_o", exit_valid, 0);
    compare_value("gpio_o", gpio_out, 0);
    compare_value("gpio_oe_o", gpio_oe, 0);
    compare_value("clk_out_o", clk_out, 1);
    prev    = clk_led;
    cnt     = 0;
    toggles = 0;
    // clock output follows the low phase too
    @(negedge clk_gen);
    #1;
    compare_value("clk_out_o", clk_out, 0);
    while (toggles < 3 && cnt <= 2 ** HEARTBEAT_BITS) begin
      @(posedge clk_gen);
      #1;
      cnt++;
      if (clk_led !== prev) begin
        compare_value("clk_led_o period", cnt, 2 ** (HEARTBEAT_BITS - 1));
        prev = clk_led;
        cnt  = 0;
        toggles++;
      end
    end
    if (toggles < 3) begin
      $display("heartbeat LED stopped toggling after reset release");
      errors++;
    end
  endtask

  initial begin
    logic [71:0] p;
    logic [31:0] rdata;
    logic [31:0] exp;
    rst_n = 1'b0;
    reg_we = 1'b0;
    reg_re = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    boot_select = 1'b0;
    execute_from_flash = 1'b0;
    gpio_in = '0;
    pins_q = '0;
    lfsr_q = 32'hc9f267b7;
    errors = 0;
    checks = 0;
    $readmemh("test/board_patterns.hex", pat_mem);
    n_pat = 0;
    while (n_pat < MAX_PAT && !$isunknown(pat_mem[n_pat])) n_pat++;
    loaded = 1'b1;
    if (n_pat == 0) begin
      $display("no patterns were loaded from test/board_patterns.hex");
      errors++;
    end
    check_reset_and_heartbeat();
    for (int i = 0; i < n_pat; i++) begin
      p = pat_mem[i];
      case (p[71:68])
        4'h0: begin
          reg_write(p[67:64], p[63:32]);
          if (p[67:64] == ADDR_EXIT) begin
            compare_value("exit_valid_o,exit_value_o", {exit_valid, exit_value}, p[31:0]);
          end else if (p[67:64] == ADDR_CTRL || p[67:64] == ADDR_GPIO_OUT) begin
            // pad flops add one cycle
            @(posedge clk_gen);
            #1;
            if (p[67:64] == ADDR_CTRL) begin
              compare_value("gpio_oe_o", gpio_oe, p[31:0]);
            end else begin
              compare_value("gpio_o", gpio_out, p[31:0]);
            end
          end
        end
        4'h1: begin
          exp = (p[67:64] == ADDR_GPIO_IN) ? pins_q : p[31:0];
          reg_read(p[67:64], rdata);
          compare_value("reg_rdata_o", rdata, exp);
        end
        4'h2: drive_pins(p[33:32]);
        4'h3: send_uart(p[63:32], p[31:0]);
        4'h4: begin
          repeat (p[63:32]) @(posedge clk_gen);
          #1;
        end
        default: begin
          $display("unknown opcode in pattern line %0d", i);
          errors++;
        end
      endcase
    end
    errors += board_top_i.board_top_checker_i.assert_errors;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             board_top_i.board_top_checker_i.assert_errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // one extra slot covers reset release and the heartbeat check
  initial begin
    wait (loaded === 1'b1);
    repeat ((n_pat + 1) * (10 * UART_DIV + 20)) @(posedge clk_gen);
    $display("watchdog expired before the pattern run finished");
    $display("TB FAILED");
    $finish;
  end

endmodule
